/* src/cpu_pkg.sv */
package cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and register map
    //////////////////////////////////////////////////////////////////////

    localparam int DAT_WIDTH = 64;
    localparam int SEL_WIDTH = DAT_WIDTH / 8;  // Byte selects
    localparam int NUM_REGS  = 32;

    typedef logic [$clog2(NUM_REGS)-1:0] reg_id_t;
    typedef logic [DAT_WIDTH-1:0]        word_t;

    localparam reg_id_t REG_PC = 5'd31;       // Program counter lives in r31

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_NOP     = 7'h00,
        OP_SET     = 7'h01,
        OP_LOAD    = 7'h02,
        OP_STORE   = 7'h03,
        OP_JUMP    = 7'h04,
        OP_TESTBIT = 7'h05,
        OP_SUB     = 7'h06,
        OP_SHIFTL  = 7'h07,
        OP_OR      = 7'h08,
        OP_AND     = 7'h09,
        OP_XOR     = 7'h0a,
        OP_HALT    = 7'h7f
    } opcode_e;

    typedef enum logic [1:0] {
        FMT_RRO = 2'd0,
        FMT_RIS = 2'd1,
        FMT_I   = 2'd2
    } format_e;

    typedef enum logic [3:0] {
        COND_ALWAYS = 4'd0,
        COND_Z      = 4'd1,   // Run only when z is set
        COND_NZ     = 4'd9    // Run only when z is clear
    } cond_e;

    // Top 13 bits, identical in every format
    typedef struct packed {
        opcode_e opcode;
        format_e fmt;
        cond_e   cond;
    } instr_hdr_t;

    typedef struct packed {
        instr_hdr_t  hdr;
        reg_id_t     rd;
        logic [40:0] imm;
        logic [4:0]  shl;
    } instr_ris_t;

    typedef struct packed {
        instr_hdr_t  hdr;
        reg_id_t     dst;
        reg_id_t     src;
        logic [40:0] off;
    } instr_rro_t;

    typedef struct packed {
        instr_hdr_t  hdr;
        logic [50:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_ris_t ris;
        instr_rro_t rro;
        instr_i_t   i;
    } instr_t;

    //////////////////////////////////////////////////////////////////////
    // Bus and internal port bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [SEL_WIDTH-1:0] sel;
        word_t                adr;
        word_t                dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat;
    } wb_s2m_t;

    typedef struct packed {
        logic  start;  // One-cycle pulse
        logic  we;
        word_t adr;
        word_t dat;
    } bus_req_t;

    typedef struct packed {
        logic  done;   // Pulse after ack
        logic  error;  // Pulse after err
        word_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic    we;
        reg_id_t id;
        word_t   wdata;
    } regfile_req_t;

    typedef struct packed {
        logic  we;
        word_t result;
        logic  z_update;
        logic  z;
    } alu_out_t;

endpackage

/* src/cpu_regfile.sv */
`timescale 1ns/1ns

module cpu_regfile #(
    parameter cpu_pkg::word_t RESET_PC = 64'h800000000000
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  cpu_pkg::regfile_req_t req_i,
    output cpu_pkg::word_t        rdata_o
);
    import cpu_pkg::*;

    word_t regs_q [NUM_REGS];

    // Single port, a write cycle leaves rdata_o as it was
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
            regs_q[REG_PC] <= RESET_PC;  // Boot address
        end else if (req_i.we) begin
            regs_q[req_i.id] <= req_i.wdata;
        end else begin
            rdata_o <= regs_q[req_i.id];
        end
    end

endmodule

/* src/cpu_alu.sv */
`timescale 1ns/1ns

module cpu_alu (
    input  cpu_pkg::instr_t   instr_i,
    input  cpu_pkg::word_t    dst_val_i,
    input  cpu_pkg::word_t    src_val_i,
    output cpu_pkg::alu_out_t out_o
);
    import cpu_pkg::*;

    word_t ris_imm;   // RIS immediate, zero-extended
    logic  amt_big;   // Shift amount or bit index past bit 63

    assign ris_imm = word_t'(instr_i.ris.imm);
    assign amt_big = (instr_i.ris.imm >= 41'(DAT_WIDTH));

    always_comb begin
        out_o = '0;
        case (instr_i.ris.hdr.opcode)
            OP_SET: begin
                if (instr_i.ris.hdr.fmt == FMT_RIS) begin
                    out_o.we     = 1'b1;
                    out_o.result = ris_imm << instr_i.ris.shl;
                end else if (instr_i.rro.hdr.fmt == FMT_RRO) begin
                    out_o.we     = 1'b1;
                    out_o.result = src_val_i;
                end
            end
            OP_SUB: begin
                out_o.we       = 1'b1;
                out_o.result   = dst_val_i - ris_imm;
                out_o.z_update = 1'b1;
                out_o.z        = (dst_val_i == ris_imm);  // Difference is zero
            end
            OP_SHIFTL: begin
                out_o.we     = 1'b1;
                out_o.result = amt_big ? '0 : dst_val_i << instr_i.ris.imm[5:0];
            end
            OP_OR: begin
                out_o.we     = 1'b1;
                out_o.result = dst_val_i | src_val_i;
            end
            OP_AND: begin
                out_o.we     = 1'b1;
                out_o.result = dst_val_i & src_val_i;
            end
            OP_XOR: begin
                out_o.we     = 1'b1;
                out_o.result = dst_val_i ^ src_val_i;
            end
            OP_TESTBIT: begin
                // Bits past the word read as clear
                out_o.z_update = 1'b1;
                out_o.z        = amt_big | ~dst_val_i[instr_i.ris.imm[5:0]];
            end
            default: begin
                out_o = '0;  // Jump, memory and halt handled by control
            end
        endcase
    end

endmodule

/* src/cpu_bus_master.sv */
`timescale 1ns/1ns

module cpu_bus_master (
    input  logic              clk_i,
    input  logic              rst_i,
    input  cpu_pkg::bus_req_t req_i,
    output cpu_pkg::bus_rsp_t rsp_o,
    input  cpu_pkg::wb_s2m_t  wb_i,
    output cpu_pkg::wb_m2s_t  wb_o
);
    import cpu_pkg::*;

    logic cyc_end;   // Slave answered this edge

    assign cyc_end = wb_o.cyc && (wb_i.ack || wb_i.err);

    //////////////////////////////////////////////////////////////////////
    // One bus cycle at a time, held until ack or err
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o.cyc    <= 1'b0;
            wb_o.stb    <= 1'b0;
            wb_o.we     <= 1'b0;
            rsp_o.done  <= 1'b0;
            rsp_o.error <= 1'b0;
        end else begin
            rsp_o.done  <= 1'b0;
            rsp_o.error <= 1'b0;
            if (cyc_end) begin
                wb_o.cyc    <= 1'b0;
                wb_o.stb    <= 1'b0;
                wb_o.we     <= 1'b0;
                rsp_o.done  <= wb_i.ack;
                rsp_o.error <= wb_i.err & ~wb_i.ack;  // ack wins
                rsp_o.rdata <= wb_i.dat;
            end else if (!wb_o.cyc && req_i.start) begin
                wb_o.cyc <= 1'b1;
                wb_o.stb <= 1'b1;
                wb_o.we  <= req_i.we;
                wb_o.sel <= {SEL_WIDTH{1'b1}};  // Always full words
                wb_o.adr <= req_i.adr;
                wb_o.dat <= req_i.dat;
            end
        end
    end

endmodule

/* src/cpu_control.sv */
`timescale 1ns/1ns

module cpu_control (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  cpu_pkg::word_t        reg_rdata_i,
    output cpu_pkg::regfile_req_t reg_req_o,
    input  cpu_pkg::alu_out_t     alu_i,
    input  cpu_pkg::bus_rsp_t     bus_rsp_i,
    output cpu_pkg::bus_req_t     bus_req_o,
    output cpu_pkg::instr_t       instr_o,
    output cpu_pkg::word_t        dst_val_o,
    output cpu_pkg::word_t        src_val_o,
    output logic                  halted_o
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        INIT,
        FETCH,
        WAIT_INSTR,
        READ_DST,
        READ_SRC,
        EXECUTE,
        WAIT_MEM,
        WRITE_BACK,
        HALT
    } state_e;

    state_e  state_q;
    instr_t  instr_q;
    word_t   src_val_q;
    logic    z_q;        // Zero flag

    instr_t  fetched;    // Instruction word as it arrives
    logic    cond_ok;
    opcode_e opcode;
    reg_id_t dst_id;
    word_t   mem_off;

    assign fetched = bus_rsp_i.rdata;
    assign opcode  = instr_q.i.hdr.opcode;
    assign dst_id  = instr_q.rro.dst;           // Same bits as ris.rd
    assign mem_off = word_t'(instr_q.rro.off);

    // .z and .nz against the current flag, anything else runs
    assign cond_ok = !((fetched.i.hdr.cond == COND_Z && !z_q) ||
                       (fetched.i.hdr.cond == COND_NZ && z_q));

    // Operands: dst comes straight off the register port in EXECUTE
    assign instr_o   = instr_q;
    assign dst_val_o = reg_rdata_i;
    assign src_val_o = src_val_q;
    assign halted_o  = (state_q == HALT);

    //////////////////////////////////////////////////////////////////////
    // Register file port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        reg_req_o    = '0;
        reg_req_o.id = REG_PC;  // Idle cycles keep the pc on rdata
        case (state_q)
            FETCH: begin
                reg_req_o.we    = 1'b1;
                reg_req_o.wdata = reg_rdata_i + 64'd8;
            end
            READ_SRC: begin
                reg_req_o.id = instr_q.rro.src;
            end
            READ_DST: begin
                reg_req_o.id = dst_id;
            end
            EXECUTE: begin
                if (opcode == OP_JUMP) begin
                    reg_req_o.we    = 1'b1;
                    reg_req_o.wdata = word_t'(instr_q.i.imm);
                end else if (alu_i.we) begin
                    reg_req_o.we    = 1'b1;
                    reg_req_o.id    = dst_id;
                    reg_req_o.wdata = alu_i.result;
                end
            end
            WAIT_MEM: begin
                if (bus_rsp_i.done && opcode == OP_LOAD) begin
                    reg_req_o.we    = 1'b1;
                    reg_req_o.id    = dst_id;
                    reg_req_o.wdata = bus_rsp_i.rdata;
                end
            end
            default: begin
                reg_req_o.we = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Bus requests, one start pulse per cycle wanted
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bus_req_o = '0;
        if (state_q == FETCH) begin
            bus_req_o.start = 1'b1;
            bus_req_o.adr   = reg_rdata_i;  // Current pc
        end else if (state_q == EXECUTE && opcode == OP_LOAD) begin
            bus_req_o.start = 1'b1;
            bus_req_o.adr   = src_val_q + mem_off;
        end else if (state_q == EXECUTE && opcode == OP_STORE) begin
            bus_req_o.start = 1'b1;
            bus_req_o.we    = 1'b1;
            bus_req_o.adr   = reg_rdata_i + mem_off;
            bus_req_o.dat   = src_val_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= INIT;
            z_q     <= 1'b0;
        end else begin
            case (state_q)
                INIT:    state_q <= FETCH;       // pc read in flight
                FETCH:   state_q <= WAIT_INSTR;
                WAIT_INSTR: begin
                    if (bus_rsp_i.error) begin
                        state_q <= HALT;
                    end else if (bus_rsp_i.done) begin
                        if (!cond_ok) begin
                            state_q <= WRITE_BACK;  // Skipped
                        end else if (fetched.i.hdr.fmt == FMT_RRO) begin
                            state_q <= READ_SRC;
                        end else if (fetched.i.hdr.fmt == FMT_RIS) begin
                            state_q <= READ_DST;
                        end else begin
                            state_q <= EXECUTE;
                        end
                    end
                end
                READ_SRC: state_q <= READ_DST;
                READ_DST: state_q <= EXECUTE;
                EXECUTE: begin
                    if (alu_i.z_update) begin
                        z_q <= alu_i.z;
                    end
                    case (opcode)
                        OP_HALT:            state_q <= HALT;
                        OP_LOAD, OP_STORE:  state_q <= WAIT_MEM;
                        default:            state_q <= WRITE_BACK;
                    endcase
                end
                WAIT_MEM: begin
                    if (bus_rsp_i.done) begin
                        state_q <= WRITE_BACK;
                    end
                end
                WRITE_BACK: state_q <= FETCH;    // Write settled, pc read
                HALT:       state_q <= HALT;     // Until reset
                default:    state_q <= HALT;
            endcase
        end
    end

    // Latched instruction and source operand
    always_ff @(posedge clk_i) begin
        if (state_q == WAIT_INSTR && bus_rsp_i.done) begin
            instr_q <= fetched;
        end
        if (state_q == READ_DST) begin
            src_val_q <= reg_rdata_i;  // Result of the READ_SRC read
        end
    end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 64'h800000000000
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  cpu_pkg::wb_s2m_t wb_i,
    output cpu_pkg::wb_m2s_t wb_o,
    output logic             halted_o
);
    import cpu_pkg::*;

    regfile_req_t reg_req;
    word_t        reg_rdata;
    alu_out_t     alu_out;
    bus_req_t     bus_req;
    bus_rsp_t     bus_rsp;
    instr_t       instr;
    word_t        dst_val;
    word_t        src_val;

    cpu_control control_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .reg_rdata_i (reg_rdata),
        .reg_req_o   (reg_req),
        .alu_i       (alu_out),
        .bus_rsp_i   (bus_rsp),
        .bus_req_o   (bus_req),
        .instr_o     (instr),
        .dst_val_o   (dst_val),
        .src_val_o   (src_val),
        .halted_o    (halted_o)
    );

    cpu_regfile #(
        .RESET_PC (RESET_PC)
    ) regfile_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (reg_req),
        .rdata_o (reg_rdata)
    );

    cpu_alu alu_inst (
        .instr_i   (instr),
        .dst_val_i (dst_val),
        .src_val_i (src_val),
        .out_o     (alu_out)
    );

    cpu_bus_master bus_master_inst (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (bus_req),
        .rsp_o (bus_rsp),
        .wb_i  (wb_i),
        .wb_o  (wb_o)
    );

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    localparam word_t RESET_PC    = 64'h800000000000;
    localparam word_t DATA_BASE   = 64'h10000000;
    localparam int    PROG_LEN    = 48;
    localparam int    DATA_WORDS  = 32;
    localparam int    WATCHDOG_NS = (PROG_LEN * 20 + 100) * 2 * 40;  // Both runs

    logic    clk_i;
    logic    rst_i;
    wb_s2m_t wb_i;
    wb_m2s_t wb_o;
    logic    halted_o;

    logic [31:0] rng_state = 32'h6deee708;

    instr_t  prog [$];
    word_t   data_init [DATA_WORDS];
    word_t   bus_mem [word_t];
    word_t   model_mem [word_t];
    wb_m2s_t exp_q [$];

    // Responder state
    logic    busy;
    wb_m2s_t cur_cyc;
    int      wait_left;
    int      cycle_cnt;
    int      err_at = -1;  // Bus cycle answered with err (-1 means none)
    logic    inject_err;

    cpu_top cpu_top_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_i     (wb_i),
        .wb_o     (wb_o),
        .halted_o (halted_o)
    );

    always #20 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_id_t random_reg(input int limit);
        return reg_id_t'(next_random() % limit);
    endfunction

    // Unwritten locations read back as a mix of the full address
    function automatic word_t fill_pattern(input word_t adr);
        return (adr * 64'h9e3779b97f4a7c15) ^ {adr[31:0], adr[63:32]};
    endfunction

    task automatic fail_test(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_test($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_test($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Write data only matters on writes
    task automatic check_m2s(input string name, input wb_m2s_t exp, input wb_m2s_t act);
        wb_m2s_t a;
        a = act;
        if (!exp.we) begin
            a.dat = exp.dat;
        end
        if (exp !== a) begin
            fail_test($sformatf("FAILED %s: expected %h, actual %h", name, exp, a));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program generation and instruction-set model
    //////////////////////////////////////////////////////////////////////

    task automatic build_program();
        instr_t      ins;
        logic [31:0] r;
        int          tgt;
        prog.delete();
        ins = '0;
        ins.ris.hdr.opcode = OP_SET;
        ins.ris.hdr.fmt    = FMT_RIS;
        ins.ris.rd         = 5'd30;  // Data base pointer
        ins.ris.imm        = 41'(DATA_BASE);
        prog.push_back(ins);
        for (int n = 1; n < PROG_LEN - 1; n++) begin
            ins = '0;
            r = next_random();
            ins.ris.hdr.fmt = FMT_RRO;
            case (r % 11)
                0: begin
                    ins.ris.hdr.opcode = OP_SET;
                    ins.ris.hdr.fmt    = FMT_RIS;
                    ins.ris.rd         = random_reg(30);
                    ins.ris.imm        = r[4] ? 41'(next_random() % 4)
                                              : {9'(next_random() % 512), next_random()};
                    ins.ris.shl        = r[4] ? 5'd0 : 5'(next_random());
                end
                1: begin
                    ins.rro.hdr.opcode = OP_SET;
                    ins.rro.dst        = random_reg(30);
                    ins.rro.src        = random_reg(31);
                end
                2, 3, 7: begin
                    ins.ris.hdr.opcode = (r % 11 == 2) ? OP_SUB :
                                         (r % 11 == 3) ? OP_SHIFTL : OP_TESTBIT;
                    ins.ris.hdr.fmt    = FMT_RIS;
                    ins.ris.rd         = random_reg(30);
                    ins.ris.imm        = (r % 11 == 2) ? 41'(next_random() % 4)
                                                       : 41'(next_random() % 70);
                end
                4, 5, 6: begin
                    ins.rro.hdr.opcode = (r % 11 == 4) ? OP_OR :
                                         (r % 11 == 5) ? OP_AND : OP_XOR;
                    ins.rro.dst        = random_reg(30);
                    ins.rro.src        = random_reg(31);
                end
                8: begin
                    tgt = n + 1 + int'(next_random() % 4);  // Forward only
                    if (tgt > PROG_LEN - 1) begin
                        tgt = PROG_LEN - 1;
                    end
                    ins.i.hdr.opcode = OP_JUMP;
                    ins.i.hdr.fmt    = FMT_I;
                    ins.i.imm        = 51'(RESET_PC + 64'(8 * tgt));
                end
                9: begin
                    ins.rro.hdr.opcode = OP_LOAD;
                    ins.rro.dst        = random_reg(30);
                    ins.rro.src        = 5'd30;
                    ins.rro.off        = 41'(8 * (next_random() % DATA_WORDS));
                end
                default: begin
                    ins.rro.hdr.opcode = OP_STORE;
                    ins.rro.dst        = 5'd30;
                    ins.rro.src        = random_reg(31);
                    ins.rro.off        = 41'(8 * (next_random() % DATA_WORDS));
                end
            endcase
            r = next_random() % 4;
            ins.i.hdr.cond = (r == 2) ? COND_Z : (r == 3) ? COND_NZ : COND_ALWAYS;
            prog.push_back(ins);
        end
        ins = '0;
        ins.i.hdr.opcode = OP_HALT;
        ins.i.hdr.fmt    = FMT_I;
        prog.push_back(ins);
        for (int k = 0; k < DATA_WORDS; k++) begin
            data_init[k] = {next_random(), next_random()};
        end
    endtask

    task automatic load_bus_memory();
        bus_mem.delete();
        foreach (prog[k]) bus_mem[RESET_PC + 64'(8 * k)] = prog[k];
        foreach (data_init[k]) bus_mem[DATA_BASE + 64'(8 * k)] = data_init[k];
    endtask

    function automatic wb_m2s_t bus_cycle(input logic we, input word_t adr, input word_t dat);
        wb_m2s_t c;
        c = '{cyc: 1'b1, stb: 1'b1, we: we, sel: '1, adr: adr, dat: dat};
        return c;
    endfunction

    // Runs the program and queues every bus cycle the DUT should make
    task automatic run_model();
        word_t  regs [NUM_REGS];
        word_t  pc;
        word_t  a;
        logic   z;
        logic   done;
        instr_t ins;
        model_mem.delete();
        foreach (prog[k]) model_mem[RESET_PC + 64'(8 * k)] = prog[k];
        foreach (data_init[k]) model_mem[DATA_BASE + 64'(8 * k)] = data_init[k];
        foreach (regs[k]) regs[k] = '0;
        exp_q.delete();
        pc = RESET_PC;
        z = 1'b0;
        done = 1'b0;
        while (!done) begin
            exp_q.push_back(bus_cycle(1'b0, pc, '0));
            ins = model_mem[pc];
            pc = pc + 64'd8;
            if ((ins.i.hdr.cond == COND_Z && !z) || (ins.i.hdr.cond == COND_NZ && z)) begin
                continue;  // Skipped
            end
            case (ins.i.hdr.opcode)
                OP_SET: begin
                    if (ins.i.hdr.fmt == FMT_RIS) begin
                        regs[ins.ris.rd] = word_t'(ins.ris.imm) << ins.ris.shl;
                    end else begin
                        regs[ins.rro.dst] = regs[ins.rro.src];
                    end
                end
                OP_SUB: begin
                    regs[ins.ris.rd] = regs[ins.ris.rd] - word_t'(ins.ris.imm);
                    z = (regs[ins.ris.rd] == '0);
                end
                OP_SHIFTL: regs[ins.ris.rd] = (ins.ris.imm >= 41'd64) ? '0
                                              : regs[ins.ris.rd] << ins.ris.imm[5:0];
                OP_OR:  regs[ins.rro.dst] = regs[ins.rro.dst] | regs[ins.rro.src];
                OP_AND: regs[ins.rro.dst] = regs[ins.rro.dst] & regs[ins.rro.src];
                OP_XOR: regs[ins.rro.dst] = regs[ins.rro.dst] ^ regs[ins.rro.src];
                OP_TESTBIT: z = (ins.ris.imm >= 41'd64) || !regs[ins.ris.rd][ins.ris.imm[5:0]];
                OP_JUMP: pc = word_t'(ins.i.imm);
                OP_LOAD: begin
                    a = regs[ins.rro.src] + word_t'(ins.rro.off);
                    exp_q.push_back(bus_cycle(1'b0, a, '0));
                    regs[ins.rro.dst] = model_mem.exists(a) ? model_mem[a] : fill_pattern(a);
                end
                OP_STORE: begin
                    a = regs[ins.rro.dst] + word_t'(ins.rro.off);
                    exp_q.push_back(bus_cycle(1'b1, a, regs[ins.rro.src]));
                    model_mem[a] = regs[ins.rro.src];
                end
                OP_HALT: done = 1'b1;
                default: ;  // Nop
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus responder with random ack delay
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (rst_i) begin
            busy = 1'b0;
            cycle_cnt = 0;
            wb_i <= '0;
        end else if (wb_i.ack || wb_i.err) begin
            busy = 1'b0;  // DUT closes the cycle at this edge
            wb_i <= '0;
        end else if (wb_o.stb) begin
            if (!busy) begin
                if (exp_q.size() == 0) begin
                    fail_test("A bus cycle started when none was expected");
                end
                if (cycle_cnt == 0) begin
                    check_word("first fetch address", RESET_PC, wb_o.adr);
                end
                check_m2s($sformatf("bus cycle %0d", cycle_cnt), exp_q.pop_front(), wb_o);
                cycle_cnt++;
                inject_err = (cycle_cnt == err_at);
                busy = 1'b1;
                cur_cyc = wb_o;
                wait_left = int'(next_random() % 4);
            end else begin
                check_m2s("bus held while waiting", cur_cyc, wb_o);
            end
            if (wait_left > 0) begin
                wait_left--;
            end else if (inject_err) begin
                wb_i <= '{ack: 1'b0, err: 1'b1, dat: '0};
                exp_q.delete();  // Nothing more after a fetch error
            end else if (wb_o.we) begin
                bus_mem[wb_o.adr] = wb_o.dat;
                wb_i <= '{ack: 1'b1, err: 1'b0, dat: '0};
            end else begin
                wb_i <= '{ack: 1'b1, err: 1'b0,
                          dat: bus_mem.exists(wb_o.adr) ? bus_mem[wb_o.adr]
                                                        : fill_pattern(wb_o.adr)};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    task automatic reset_dut();
        rst_i <= 1'b1;
        repeat (5) @(posedge clk_i);
        check_bit("cyc after reset", 1'b0, wb_o.cyc);
        check_bit("stb after reset", 1'b0, wb_o.stb);
        check_bit("we after reset", 1'b0, wb_o.we);
        check_bit("halted after reset", 1'b0, halted_o);
        rst_i <= 1'b0;
    endtask

    task automatic watch_idle(input string name);
        repeat (20) begin
            @(posedge clk_i);
            check_bit({name, " strobe"}, 1'b0, wb_o.stb);
            check_bit({name, " halted"}, 1'b1, halted_o);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        wb_i  = '0;
        build_program();

        // First run goes through the whole program to halt
        load_bus_memory();
        run_model();
        reset_dut();
        while (halted_o !== 1'b1) @(posedge clk_i);
        check_word("bus cycles left at halt", '0, word_t'(exp_q.size()));
        watch_idle("after halt");

        // Second run answers the third bus cycle (a fetch) with err
        err_at = 3;
        load_bus_memory();
        run_model();
        reset_dut();
        while (halted_o !== 1'b1) @(posedge clk_i);
        check_word("bus cycles before fetch error", 64'd3, word_t'(cycle_cnt));
        watch_idle("after fetch error");

        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_test("Timeout: the processor did not halt in the expected time");
    end

endmodule

/* cpu_top.f */
src/cpu_pkg.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_bus_master.sv
src/cpu_control.sv
src/cpu_top.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cpu_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module cpu_tb -f cpu_top.f -o cpu_sim > build.log 2>&1 &&
    ./obj_dir/cpu_sim > sim.log 2>&1
grep -q "PASS: all tests" sim.log && echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
